// File: design/regfile_pkg.sv
package regfile_pkg;

    // register file geometry
    localparam int ENTRY_WIDTH = 32;
    localparam int N_ENTRIES = 32;
    localparam int PTR_WIDTH = $clog2(N_ENTRIES);

    // core side ports
    localparam int N_CORE_READ_PORTS = 2;
    localparam int N_CORE_WRITE_PORTS = 2;

    // one extra read and write port for the debug slave, always the highest index
    localparam int N_READ_PORTS = N_CORE_READ_PORTS + 1;
    localparam int N_WRITE_PORTS = N_CORE_WRITE_PORTS + 1;

    // debug bus
    localparam int AXI_ADDR_WIDTH = 8;
    localparam int AXI_DATA_WIDTH = 32;

    // entries sit at 0x00..0x7c, control word right after them
    localparam logic [AXI_ADDR_WIDTH-1:0] CTRL_ADDR = 8'h80;

    // response codes
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

// File: design/write_select.sv
`timescale 1ns/1ps

module write_select
    import regfile_pkg::*;
(
    input  logic [N_WRITE_PORTS-1:0]                  wr_en,
    input  logic [N_WRITE_PORTS-1:0][PTR_WIDTH-1:0]   wr_addr,
    input  logic [N_WRITE_PORTS-1:0][ENTRY_WIDTH-1:0] wr_data,
    output logic [N_ENTRIES-1:0]                      entry_we,
    output logic [N_ENTRIES-1:0][ENTRY_WIDTH-1:0]     entry_din
);

    // per entry: which ports hit it, then lowest port index wins
    always_comb begin
        logic [N_WRITE_PORTS-1:0] hit;
        logic                     found;

        entry_we = '0;
        entry_din = '0;
        hit = '0;
        found = 1'b0;

        for (int e = 0; e < N_ENTRIES; e++) begin
            // address decode gated by enable
            for (int p = 0; p < N_WRITE_PORTS; p++) begin
                hit[p] = wr_en[p] && (wr_addr[p] == PTR_WIDTH'(e));
            end

            entry_we[e] = |hit;

            // find first one from port 0 upward
            found = 1'b0;
            for (int p = 0; p < N_WRITE_PORTS; p++) begin
                if (hit[p] && !found) begin
                    entry_din[e] = wr_data[p];
                    found = 1'b1;
                end
            end
        end
    end

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps

module regfile
    import regfile_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      flush,

    input  logic [N_READ_PORTS-1:0][PTR_WIDTH-1:0]    rd_addr,
    output logic [N_READ_PORTS-1:0][ENTRY_WIDTH-1:0]  rd_data,

    input  logic [N_WRITE_PORTS-1:0]                  wr_en,
    input  logic [N_WRITE_PORTS-1:0][PTR_WIDTH-1:0]   wr_addr,
    input  logic [N_WRITE_PORTS-1:0][ENTRY_WIDTH-1:0] wr_data
);

    logic [N_ENTRIES-1:0]                  entry_we;
    logic [N_ENTRIES-1:0][ENTRY_WIDTH-1:0] entry_din;
    logic [N_ENTRIES-1:0][ENTRY_WIDTH-1:0] entries;

    write_select u_write_select (
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .entry_we  (entry_we),
        .entry_din (entry_din)
    );

    // flush beats any write in the same cycle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            entries <= '0;
        end else begin
            for (int e = 0; e < N_ENTRIES; e++) begin
                if (entry_we[e]) begin
                    entries[e] <= entry_din[e];
                end
            end
        end
    end

    // no bypass, reads see the stored value only
    for (genvar i = 0; i < N_READ_PORTS; i++) begin : g_rd
        assign rd_data[i] = entries[rd_addr[i]];
    end

    // true when port p targets entry e and no lower port does
    function automatic logic port_wins(
        input logic [N_WRITE_PORTS-1:0]                en,
        input logic [N_WRITE_PORTS-1:0][PTR_WIDTH-1:0] addr,
        input int                                      p,
        input int                                      e
    );
        logic lower;
        lower = 1'b0;
        for (int q = 0; q < p; q++) begin
            if (en[q] && addr[q] == PTR_WIDTH'(e)) begin
                lower = 1'b1;
            end
        end
        return en[p] && (addr[p] == PTR_WIDTH'(e)) && !lower;
    endfunction

    for (genvar e = 0; e < N_ENTRIES; e++) begin : g_chk
        for (genvar p = 0; p < N_WRITE_PORTS; p++) begin : g_port
            a_write_priority: assert property (@(posedge clk) disable iff (reset)
                port_wins(wr_en, wr_addr, p, e) && !flush |=> entries[e] == $past(wr_data[p]));
        end

        a_entry_hold: assert property (@(posedge clk) disable iff (reset)
            !flush && !entry_we[e] |=> $stable(entries[e]));
    end

endmodule

// File: design/axil_debug_port.sv
`timescale 1ns/1ps

module axil_debug_port
    import regfile_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    // write address / data / response
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [AXI_ADDR_WIDTH-1:0]   awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [AXI_DATA_WIDTH-1:0]   wdata,
    input  logic [AXI_DATA_WIDTH/8-1:0] wstrb,
    output logic                        bvalid,
    input  logic                        bready,
    output logic [1:0]                  bresp,

    // read address / data
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [AXI_ADDR_WIDTH-1:0]   araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [AXI_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                  rresp,

    // register file side
    output logic [PTR_WIDTH-1:0]        dbg_rd_addr,
    input  logic [ENTRY_WIDTH-1:0]      dbg_rd_data,
    output logic                        dbg_wr_en,
    output logic [PTR_WIDTH-1:0]        dbg_wr_addr,
    output logic [ENTRY_WIDTH-1:0]      dbg_wr_data,
    output logic                        dbg_flush
);

    logic                      wr_ready_q;
    logic                      aw_hs;
    logic                      ar_hs;
    logic [PTR_WIDTH-1:0]      rd_idx;
    logic                      rd_entry;
    logic                      rd_first;
    logic [AXI_DATA_WIDTH-1:0] rdata_q;

    // word aligned and below the control word
    function automatic logic is_entry(input logic [AXI_ADDR_WIDTH-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr < CTRL_ADDR);
    endfunction

    function automatic logic is_ctrl(input logic [AXI_ADDR_WIDTH-1:0] addr);
        return addr == CTRL_ADDR;
    endfunction

    // aw and w are accepted as a pair
    assign awready = wr_ready_q;
    assign wready = wr_ready_q;
    assign aw_hs = awvalid && awready && wvalid && wready;
    assign ar_hs = arvalid && arready;

    // single-cycle ready pulse once both halves are present and b is idle
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ready_q <= 1'b0;
        end else begin
            wr_ready_q <= awvalid && wvalid && !wr_ready_q && !bvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid <= 1'b0;
            dbg_wr_en <= 1'b0;
            dbg_flush <= 1'b0;
        end else begin
            dbg_wr_en <= aw_hs && is_entry(awaddr);
            dbg_flush <= aw_hs && is_ctrl(awaddr) && wdata[0];
            if (aw_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // wstrb not used, full words only
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            dbg_wr_addr <= awaddr[PTR_WIDTH+1:2];
            dbg_wr_data <= wdata;
            bresp <= (is_entry(awaddr) || is_ctrl(awaddr)) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
    end

    // read side, one outstanding read
    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
            rd_first <= 1'b0;
        end else begin
            arready <= !ar_hs && !(rvalid && !rready);
            rd_first <= ar_hs;
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_idx <= araddr[PTR_WIDTH+1:2];
            rd_entry <= is_entry(araddr);
            rresp <= (is_entry(araddr) || is_ctrl(araddr)) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        end
        // keep the first-cycle value so later writes don't disturb the response
        if (rd_first) begin
            rdata_q <= rdata;
        end
    end

    assign dbg_rd_addr = rd_idx;

    // ctrl and error reads return zero
    assign rdata = rd_first ? (rd_entry ? dbg_rd_data : '0) : rdata_q;

    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata));

    a_wr_flush_excl: assert property (@(posedge clk) disable iff (reset)
        !(dbg_wr_en && dbg_flush));

endmodule

// File: design/regfile_top.sv
`timescale 1ns/1ps

module regfile_top
    import regfile_pkg::*;
(
    input  logic                                           clk,
    input  logic                                           reset,

    // core ports
    input  logic [N_CORE_READ_PORTS-1:0][PTR_WIDTH-1:0]    rd_addr,
    output logic [N_CORE_READ_PORTS-1:0][ENTRY_WIDTH-1:0]  rd_data,
    input  logic [N_CORE_WRITE_PORTS-1:0]                  wr_en,
    input  logic [N_CORE_WRITE_PORTS-1:0][PTR_WIDTH-1:0]   wr_addr,
    input  logic [N_CORE_WRITE_PORTS-1:0][ENTRY_WIDTH-1:0] wr_data,
    input  logic                                           flush,

    // debug AXI4-Lite slave
    input  logic                                           awvalid,
    output logic                                           awready,
    input  logic [AXI_ADDR_WIDTH-1:0]                      awaddr,
    input  logic                                           wvalid,
    output logic                                           wready,
    input  logic [AXI_DATA_WIDTH-1:0]                      wdata,
    input  logic [AXI_DATA_WIDTH/8-1:0]                    wstrb,
    output logic                                           bvalid,
    input  logic                                           bready,
    output logic [1:0]                                     bresp,
    input  logic                                           arvalid,
    output logic                                           arready,
    input  logic [AXI_ADDR_WIDTH-1:0]                      araddr,
    output logic                                           rvalid,
    input  logic                                           rready,
    output logic [AXI_DATA_WIDTH-1:0]                      rdata,
    output logic [1:0]                                     rresp
);

    logic [PTR_WIDTH-1:0]                      dbg_rd_addr;
    logic                                      dbg_wr_en;
    logic [PTR_WIDTH-1:0]                      dbg_wr_addr;
    logic [ENTRY_WIDTH-1:0]                    dbg_wr_data;
    logic                                      dbg_flush;

    logic [N_READ_PORTS-1:0][PTR_WIDTH-1:0]    rf_rd_addr;
    logic [N_READ_PORTS-1:0][ENTRY_WIDTH-1:0]  rf_rd_data;
    logic [N_WRITE_PORTS-1:0]                  rf_wr_en;
    logic [N_WRITE_PORTS-1:0][PTR_WIDTH-1:0]   rf_wr_addr;
    logic [N_WRITE_PORTS-1:0][ENTRY_WIDTH-1:0] rf_wr_data;

    // debug takes the top port index, so lowest write priority
    assign rf_rd_addr = {dbg_rd_addr, rd_addr};
    assign rd_data = rf_rd_data[N_CORE_READ_PORTS-1:0];
    assign rf_wr_en = {dbg_wr_en, wr_en};
    assign rf_wr_addr = {dbg_wr_addr, wr_addr};
    assign rf_wr_data = {dbg_wr_data, wr_data};

    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush || dbg_flush),
        .rd_addr (rf_rd_addr),
        .rd_data (rf_rd_data),
        .wr_en   (rf_wr_en),
        .wr_addr (rf_wr_addr),
        .wr_data (rf_wr_data)
    );

    axil_debug_port u_axil_debug_port (
        .clk         (clk),
        .reset       (reset),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .dbg_rd_addr (dbg_rd_addr),
        .dbg_rd_data (rf_rd_data[N_READ_PORTS-1]),
        .dbg_wr_en   (dbg_wr_en),
        .dbg_wr_addr (dbg_wr_addr),
        .dbg_wr_data (dbg_wr_data),
        .dbg_flush   (dbg_flush)
    );

endmodule

// File: dv/tb_regfile_top.sv
`timescale 1ns/1ps

module tb_regfile_top
    import regfile_pkg::*;
();

    logic                                           clk;
    logic                                           reset;
    logic [N_CORE_READ_PORTS-1:0][PTR_WIDTH-1:0]    rd_addr;
    logic [N_CORE_READ_PORTS-1:0][ENTRY_WIDTH-1:0]  rd_data;
    logic [N_CORE_WRITE_PORTS-1:0]                  wr_en;
    logic [N_CORE_WRITE_PORTS-1:0][PTR_WIDTH-1:0]   wr_addr;
    logic [N_CORE_WRITE_PORTS-1:0][ENTRY_WIDTH-1:0] wr_data;
    logic                                           flush;
    logic                                           awvalid;
    logic                                           awready;
    logic [AXI_ADDR_WIDTH-1:0]                      awaddr;
    logic                                           wvalid;
    logic                                           wready;
    logic [AXI_DATA_WIDTH-1:0]                      wdata;
    logic [AXI_DATA_WIDTH/8-1:0]                    wstrb;
    logic                                           bvalid;
    logic                                           bready;
    logic [1:0]                                     bresp;
    logic                                           arvalid;
    logic                                           arready;
    logic [AXI_ADDR_WIDTH-1:0]                      araddr;
    logic                                           rvalid;
    logic                                           rready;
    logic [AXI_DATA_WIDTH-1:0]                      rdata;
    logic [1:0]                                     rresp;

    integer seed;

    // reference state of the register file
    logic [ENTRY_WIDTH-1:0] model [N_ENTRIES];

    // debug write accepted last cycle, takes effect at the end of this one
    bit                     pend_wr;
    bit                     pend_flush;
    logic [PTR_WIDTH-1:0]   pend_idx;
    logic [ENTRY_WIDTH-1:0] pend_data;

    bit                     exp_bvalid;
    logic [1:0]             exp_bresp;
    bit                     exp_rvalid;
    logic [1:0]             exp_rresp;
    logic [ENTRY_WIDTH-1:0] exp_rdata;

    bit aw_active;
    bit ar_active;
    bit aw_rdy;
    bit ar_rdy;
    int aw_wait;
    int ar_wait;
    bit quiesce;
    int drain_cycles;

    regfile_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int unsigned rnd(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic bit maps_entry(input logic [AXI_ADDR_WIDTH-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr < 8'h80);
    endfunction

    function automatic logic [1:0] resp_for(input logic [AXI_ADDR_WIDTH-1:0] addr);
        if (maps_entry(addr) || addr == 8'h80) begin
            return AXI_RESP_OKAY;
        end
        return AXI_RESP_SLVERR;
    endfunction

    // mostly entries, some control, some unaligned or unmapped
    function automatic logic [AXI_ADDR_WIDTH-1:0] pick_addr();
        int unsigned sel;
        sel = rnd(10);
        if (sel < 7) begin
            return {1'b0, 5'(rnd(32)), 2'b00};
        end else if (sel == 7) begin
            return CTRL_ADDR;
        end else if (sel == 8) begin
            return {1'b0, 5'(rnd(32)), 2'(1 + rnd(3))};
        end
        return 8'(8'h84 + rnd(124));
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic drive_inputs();
        int unsigned p;
        rd_addr[0] = PTR_WIDTH'(rnd(N_ENTRIES));
        rd_addr[1] = PTR_WIDTH'(rnd(N_ENTRIES));
        wr_en = quiesce ? 2'b00 : 2'(rnd(4));
        wr_addr[0] = PTR_WIDTH'(rnd(N_ENTRIES));
        // same-entry collision about a quarter of the time
        wr_addr[1] = (rnd(4) == 0) ? wr_addr[0] : PTR_WIDTH'(rnd(N_ENTRIES));
        wr_data[0] = $random(seed);
        wr_data[1] = $random(seed);
        // aim a core write at the pending debug write
        if (pend_wr && !quiesce && rnd(2) == 0) begin
            p = rnd(2);
            wr_en[p] = 1'b1;
            wr_addr[p] = pend_idx;
        end
        flush = !quiesce && (rnd(40) == 0);

        if (!aw_active && !quiesce && rnd(4) == 0) begin
            aw_active = 1'b1;
            awaddr = pick_addr();
            wdata = $random(seed);
            if (awaddr == CTRL_ADDR) begin
                wdata[0] = (rnd(3) == 0);
            end
            wstrb = 4'(rnd(16));
        end
        awvalid = aw_active;
        wvalid = aw_active;
        bready = quiesce || (rnd(3) != 0);

        if (!ar_active && !quiesce && rnd(3) == 0) begin
            ar_active = 1'b1;
            araddr = pick_addr();
        end
        arvalid = ar_active;
        rready = quiesce || (rnd(3) != 0);
    endtask

    task automatic check_outputs();
        aw_rdy = awready && wready;
        ar_rdy = arready;
        for (int i = 0; i < N_CORE_READ_PORTS; i++) begin
            assert (rd_data[i] == model[rd_addr[i]]) else
                report_error($sformatf("mismatch rd_data[%0d] got %h expected %h",
                    i, rd_data[i], model[rd_addr[i]]));
        end
        assert (bvalid == exp_bvalid) else
            report_error($sformatf("mismatch bvalid got %h expected %h", bvalid, exp_bvalid));
        if (exp_bvalid) begin
            assert (bresp == exp_bresp) else
                report_error($sformatf("mismatch bresp got %h expected %h", bresp, exp_bresp));
        end
        assert (rvalid == exp_rvalid) else
            report_error($sformatf("mismatch rvalid got %h expected %h", rvalid, exp_rvalid));
        if (exp_rvalid) begin
            assert (rresp == exp_rresp) else
                report_error($sformatf("mismatch rresp got %h expected %h", rresp, exp_rresp));
            assert (rdata == exp_rdata) else
                report_error($sformatf("mismatch rdata got %h expected %h", rdata, exp_rdata));
        end

        // ready rules of both request channels
        assert (arready == !exp_rvalid) else
            report_error($sformatf("mismatch arready got %h expected %h",
                arready, !exp_rvalid));
        assert (awready == wready) else
            report_error("awready and wready did not rise together");
        assert (!aw_rdy || (aw_active && !exp_bvalid)) else
            report_error("write ready raised without a request or with a response pending");

        // handshake timeouts
        aw_wait = (aw_active && !aw_rdy) ? aw_wait + 1 : 0;
        ar_wait = (ar_active && !ar_rdy) ? ar_wait + 1 : 0;
        if (aw_wait > 50) begin
            report_error("debug write address and data handshake never completed");
        end
        if (ar_wait > 50) begin
            report_error("debug read address handshake never completed");
        end
    endtask

    // model of the clock edge ending this cycle
    task automatic update_model();
        if (flush || pend_flush) begin
            for (int e = 0; e < N_ENTRIES; e++) begin
                model[e] = '0;
            end
        end else begin
            // lowest priority first so port 0 ends up on top
            if (pend_wr) begin
                model[pend_idx] = pend_data;
            end
            for (int p = N_CORE_WRITE_PORTS - 1; p >= 0; p--) begin
                if (wr_en[p]) begin
                    model[wr_addr[p]] = wr_data[p];
                end
            end
        end
        pend_wr = 1'b0;
        pend_flush = 1'b0;

        if (exp_bvalid && bready) begin
            exp_bvalid = 1'b0;
        end
        if (aw_active && aw_rdy) begin
            aw_active = 1'b0;
            exp_bvalid = 1'b1;
            exp_bresp = resp_for(awaddr);
            pend_wr = maps_entry(awaddr);
            pend_idx = awaddr[6:2];
            pend_data = wdata;
            pend_flush = (awaddr == CTRL_ADDR) && wdata[0];
        end

        if (exp_rvalid && rready) begin
            exp_rvalid = 1'b0;
        end
        // read data reflects the entries after this edge
        if (ar_active && ar_rdy) begin
            ar_active = 1'b0;
            exp_rvalid = 1'b1;
            exp_rresp = resp_for(araddr);
            exp_rdata = maps_entry(araddr) ? model[araddr[6:2]] : '0;
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        drive_inputs();
        #2;
        check_outputs();
        @(posedge clk);
        update_model();
    endtask

    initial begin
        seed = 32'hd0c1673b;
        reset = 1'b1;
        rd_addr = '0;
        wr_en = '0;
        wr_addr = '0;
        wr_data = '0;
        flush = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        for (int e = 0; e < N_ENTRIES; e++) begin
            model[e] = '0;
        end
        pend_wr = 1'b0;
        pend_flush = 1'b0;
        exp_bvalid = 1'b0;
        exp_rvalid = 1'b0;
        aw_active = 1'b0;
        ar_active = 1'b0;
        aw_wait = 0;
        ar_wait = 0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // idle reads right after reset, everything should be zero
        quiesce = 1'b1;
        repeat (10) run_cycle();

        quiesce = 1'b0;
        repeat (4000) run_cycle();

        // let outstanding debug traffic finish
        quiesce = 1'b1;
        drain_cycles = 0;
        while (aw_active || ar_active || exp_bvalid || exp_rvalid) begin
            run_cycle();
            drain_cycles++;
            if (drain_cycles > 100) begin
                report_error("outstanding debug transactions never drained");
            end
        end
        repeat (4) run_cycle();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: src.f
design/regfile_pkg.sv
design/write_select.sv
design/regfile.sv
design/axil_debug_port.sv
design/regfile_top.sv
dv/tb_regfile_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_regfile_top -f src.f -o sim_regfile \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_regfile > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
